//--- source/cx_pkg.sv
`default_nettype none

package cx_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int CX_DATA_W   = 32;
  localparam int CX_FUNC_W   = 25;
  localparam int CX_SEL_W    = 2;
  // Response status bits from 0 upward are ci, si, fi, op
  localparam int CX_STATUS_W = 4;

  // Custom opcodes accepted by the request path
  localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;
  localparam logic [6:0] OPC_CUSTOM1 = 7'b0101011;

  ////////////////////////////////////////////////////////////
  // Host register map, word offsets on address bits 4:2
  ////////////////////////////////////////////////////////////

  localparam logic [2:0] REG_INSN   = 3'd0;
  localparam logic [2:0] REG_DATA0  = 3'd1;
  localparam logic [2:0] REG_DATA1  = 3'd2;
  localparam logic [2:0] REG_SEL    = 3'd3;
  localparam logic [2:0] REG_CMD    = 3'd4;
  localparam logic [2:0] REG_STATUS = 3'd5;
  localparam logic [2:0] REG_RESULT = 3'd6;

  // Status word layout
  localparam int ST_BUSY      = 0;
  localparam int ST_DONE      = 1;
  localparam int ST_ILLEGAL   = 2;
  localparam int ST_FLAGS_LSB = 4;
  localparam int ST_CNT_LSB   = 8;

  // Selector word layout
  localparam int SEL_CXU_LSB   = 0;
  localparam int SEL_STATE_LSB = 2;
  localparam int SEL_VIRT_LSB  = 4;

  ////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////

  typedef union packed {
    // R-type layout
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    // Everything above the opcode as one function field
    struct packed {
      logic [CX_FUNC_W-1:0] func;
      logic [6:0]           opcode;
    } f;
  } cx_insn_u;

endpackage

`default_nettype wire

//--- source/cx_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cx_wb_regs import cx_pkg::*; #(
  parameter int CNT_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Wishbone classic slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [4:2]             wb_adr_i,
  input  logic [CX_DATA_W-1:0]   wb_dat_i,
  output logic [CX_DATA_W-1:0]   wb_dat_o,
  output logic                   wb_ack_o,

  // Request setup
  output cx_insn_u               insn_o,
  output logic [CX_DATA_W-1:0]   data0_o,
  output logic [CX_DATA_W-1:0]   data1_o,
  output logic [CX_SEL_W-1:0]    cxu_id_o,
  output logic [CX_SEL_W-1:0]    state_id_o,
  output logic [CX_SEL_W-1:0]    virt_state_id_o,
  output logic                   go_o,

  // From the request tracker
  input  logic                   busy_i,
  input  logic [CX_DATA_W-1:0]   result_i,

  // From the status block
  input  logic                   done_i,
  input  logic                   illegal_i,
  input  logic [CX_STATUS_W-1:0] flags_i,
  input  logic [CNT_W-1:0]       count_i,
  output logic [CX_STATUS_W-1:0] clr_flags_o,
  output logic                   clr_illegal_o,
  output logic                   clr_done_o
);

  cx_insn_u                  insn_q;
  logic [CX_DATA_W-1:0]      data0_q;
  logic [CX_DATA_W-1:0]      data1_q;
  logic [3*CX_SEL_W-1:0]     sel_q;
  logic                      ack_q;
  logic                      wr_en;
  logic                      wr_status;
  logic [CX_DATA_W-1:0]      status_word;
  logic [CX_DATA_W-1:0]      rd_data;

  ////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////

  // Single-cycle ack, one clock after the strobe is seen
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
    end
  end

  assign wb_ack_o  = ack_q;
  assign wr_en     = ack_q & wb_cyc_i & wb_stb_i & wb_we_i;
  assign wr_status = wr_en & (wb_adr_i == REG_STATUS);

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q  <= '0;
      data0_q <= '0;
      data1_q <= '0;
      sel_q   <= '0;
    end else if (wr_en) begin
      case (wb_adr_i)
        REG_INSN:  insn_q  <= wb_dat_i;
        REG_DATA0: data0_q <= wb_dat_i;
        REG_DATA1: data1_q <= wb_dat_i;
        REG_SEL:   sel_q   <= wb_dat_i[3*CX_SEL_W-1:0];
        default: ;
      endcase
    end
  end

  assign insn_o          = insn_q;
  assign data0_o         = data0_q;
  assign data1_o         = data1_q;
  assign cxu_id_o        = sel_q[SEL_CXU_LSB +: CX_SEL_W];
  assign state_id_o      = sel_q[SEL_STATE_LSB +: CX_SEL_W];
  assign virt_state_id_o = sel_q[SEL_VIRT_LSB +: CX_SEL_W];

  // Command and write-1-to-clear strobes, all in the ack cycle
  assign go_o          = wr_en & (wb_adr_i == REG_CMD) & wb_dat_i[0];
  assign clr_flags_o   = wr_status ? wb_dat_i[ST_FLAGS_LSB +: CX_STATUS_W] : '0;
  assign clr_illegal_o = wr_status & wb_dat_i[ST_ILLEGAL];
  assign clr_done_o    = wr_status & wb_dat_i[ST_DONE];

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    status_word                                 = '0;
    status_word[ST_BUSY]                        = busy_i;
    status_word[ST_DONE]                        = done_i;
    status_word[ST_ILLEGAL]                     = illegal_i;
    status_word[ST_FLAGS_LSB +: CX_STATUS_W]    = flags_i;
    status_word[ST_CNT_LSB +: CNT_W]            = count_i;
  end

  // CMD is write-only and reads as zero like unmapped offsets
  always_comb begin
    case (wb_adr_i)
      REG_INSN:   rd_data = insn_q;
      REG_DATA0:  rd_data = data0_q;
      REG_DATA1:  rd_data = data1_q;
      REG_SEL:    rd_data = {{(CX_DATA_W-3*CX_SEL_W){1'b0}}, sel_q};
      REG_STATUS: rd_data = status_word;
      REG_RESULT: rd_data = result_i;
      default:    rd_data = '0;
    endcase
  end

  assign wb_dat_o = rd_data;

endmodule

`default_nettype wire

//--- source/cx_req_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module cx_req_fsm import cx_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // From the register block
  input  logic                   go_i,
  input  cx_insn_u               insn_i,
  input  logic [CX_DATA_W-1:0]   data0_i,
  input  logic [CX_DATA_W-1:0]   data1_i,

  // CX request and response handshake
  output logic                   cx_req_valid_o,
  input  logic                   cx_req_ready_i,
  output logic                   cx_resp_ready_o,
  input  logic                   cx_resp_valid_i,
  input  logic [CX_DATA_W-1:0]   cx_resp_data_i,
  input  logic [CX_STATUS_W-1:0] cx_resp_status_i,
  output logic [CX_DATA_W-1:0]   cx_req_data0_o,
  output logic [CX_DATA_W-1:0]   cx_req_data1_o,
  output logic [CX_FUNC_W-1:0]   cx_func_o,
  output logic [CX_DATA_W-1:0]   cx_insn_o,

  // Result and events
  output logic                   busy_o,
  output logic [CX_DATA_W-1:0]   result_o,
  output logic                   illegal_o,
  output logic                   done_o,
  output logic [CX_STATUS_W-1:0] status_o
);

  localparam logic [1:0] S_IDLE        = 2'd0;
  localparam logic [1:0] S_AWAIT_READY = 2'd1;
  localparam logic [1:0] S_AWAIT_RESP  = 2'd2;

  logic [1:0]             state_q;
  logic [1:0]             state_d;
  cx_insn_u               insn_q;
  logic [CX_DATA_W-1:0]   data0_q;
  logic [CX_DATA_W-1:0]   data1_q;
  logic [CX_DATA_W-1:0]   result_q;
  logic [CX_STATUS_W-1:0] status_q;
  logic                   done_q;
  logic                   legal;
  logic                   start;
  logic                   resp_take;

  // Only the two custom opcodes are forwarded to the unit
  assign legal = (insn_i.r.opcode == OPC_CUSTOM0) || (insn_i.r.opcode == OPC_CUSTOM1);

  // Busy also covers the cycle in which the done pulse is out
  assign busy_o    = (state_q != S_IDLE) | done_q;
  assign start     = go_i & ~busy_o;
  assign illegal_o = start & ~legal;
  assign resp_take = (state_q == S_AWAIT_RESP) & cx_resp_valid_i;

  ////////////////////////////////////////////////////////////
  // Request tracker
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:        if (start && legal) state_d = S_AWAIT_READY;
      S_AWAIT_READY: if (cx_req_ready_i) state_d = S_AWAIT_RESP;
      S_AWAIT_RESP:  if (cx_resp_valid_i) state_d = S_IDLE;
      default:       state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= resp_take;
    end
  end

  // Request payload, frozen for the whole transaction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q  <= '0;
      data0_q <= '0;
      data1_q <= '0;
    end else if (start && legal) begin
      insn_q  <= insn_i;
      data0_q <= data0_i;
      data1_q <= data1_i;
    end
  end

  // Response capture
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
      status_q <= '0;
    end else if (resp_take) begin
      result_q <= cx_resp_data_i;
      status_q <= cx_resp_status_i;
    end
  end

  assign cx_req_valid_o  = (state_q == S_AWAIT_READY);
  assign cx_resp_ready_o = (state_q == S_AWAIT_RESP);
  assign cx_req_data0_o  = data0_q;
  assign cx_req_data1_o  = data1_q;
  assign cx_func_o       = insn_q.f.func;
  assign cx_insn_o       = insn_q;

  assign result_o = result_q;
  assign done_o   = done_q;
  assign status_o = status_q;

endmodule

`default_nettype wire

//--- source/cx_status_csr.sv
`timescale 1ns/10ps
`default_nettype none

module cx_status_csr import cx_pkg::*; #(
  parameter int CNT_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Events from the request tracker
  input  logic                   done_i,
  input  logic                   illegal_i,
  input  logic [CX_STATUS_W-1:0] status_i,

  // Write-1-to-clear strobes
  input  logic [CX_STATUS_W-1:0] clr_flags_i,
  input  logic                   clr_illegal_i,
  input  logic                   clr_done_i,

  output logic                   done_o,
  output logic                   illegal_o,
  output logic [CX_STATUS_W-1:0] flags_o,
  output logic [CNT_W-1:0]       count_o
);

  logic                   done_q;
  logic                   illegal_q;
  logic [CX_STATUS_W-1:0] flags_q;
  logic [CX_STATUS_W-1:0] flags_set;
  logic [CNT_W-1:0]       count_q;

  ////////////////////////////////////////////////////////////
  // Sticky response flags
  ////////////////////////////////////////////////////////////

  // A new status bit overrides a clear of the same bit
  assign flags_set = done_i ? status_i : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_q <= '0;
    end else begin
      flags_q <= (flags_q & ~clr_flags_i) | flags_set;
    end
  end

  ////////////////////////////////////////////////////////////
  // Done, illegal and completion count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q  <= 1'b0;
      count_q <= '0;
    end else if (done_i) begin
      done_q <= 1'b1;
      // Saturate rather than wrap
      if (count_q != {CNT_W{1'b1}}) begin
        count_q <= count_q + 1'b1;
      end
    end else if (clr_done_i) begin
      done_q  <= 1'b0;
      count_q <= '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
    end else if (illegal_i) begin
      illegal_q <= 1'b1;
    end else if (clr_illegal_i) begin
      illegal_q <= 1'b0;
    end
  end

  assign done_o    = done_q;
  assign illegal_o = illegal_q;
  assign flags_o   = flags_q;
  assign count_o   = count_q;

endmodule

`default_nettype wire

//--- source/cx_host_top.sv
`timescale 1ns/10ps
`default_nettype none

module cx_host_top import cx_pkg::*; #(
  parameter int CNT_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Host side
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [4:2]             wb_adr_i,
  input  logic [CX_DATA_W-1:0]   wb_dat_i,
  output logic [CX_DATA_W-1:0]   wb_dat_o,
  output logic                   wb_ack_o,

  // CX unit side
  output logic                   cx_req_valid_o,
  input  logic                   cx_req_ready_i,
  output logic                   cx_resp_ready_o,
  input  logic                   cx_resp_valid_i,
  input  logic [CX_DATA_W-1:0]   cx_resp_data_i,
  input  logic [CX_STATUS_W-1:0] cx_resp_status_i,
  output logic [CX_DATA_W-1:0]   cx_req_data0_o,
  output logic [CX_DATA_W-1:0]   cx_req_data1_o,
  output logic [CX_FUNC_W-1:0]   cx_func_o,
  output logic [CX_DATA_W-1:0]   cx_insn_o,
  output logic [CX_SEL_W-1:0]    cx_cxu_id_o,
  output logic [CX_SEL_W-1:0]    cx_state_id_o,
  output logic [CX_SEL_W-1:0]    cx_virt_state_id_o
);

  cx_insn_u               insn;
  logic [CX_DATA_W-1:0]   data0;
  logic [CX_DATA_W-1:0]   data1;
  logic                   go;
  logic                   busy;
  logic [CX_DATA_W-1:0]   result;
  logic                   illegal_pulse;
  logic                   done_pulse;
  logic [CX_STATUS_W-1:0] resp_status;
  logic                   done_flag;
  logic                   illegal_flag;
  logic [CX_STATUS_W-1:0] flags;
  logic [CNT_W-1:0]       count;
  logic [CX_STATUS_W-1:0] clr_flags;
  logic                   clr_illegal;
  logic                   clr_done;

  cx_wb_regs #(
    .CNT_W (CNT_W)
  ) u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .insn_o          (insn),
    .data0_o         (data0),
    .data1_o         (data1),
    .cxu_id_o        (cx_cxu_id_o),
    .state_id_o      (cx_state_id_o),
    .virt_state_id_o (cx_virt_state_id_o),
    .go_o            (go),
    .busy_i          (busy),
    .result_i        (result),
    .done_i          (done_flag),
    .illegal_i       (illegal_flag),
    .flags_i         (flags),
    .count_i         (count),
    .clr_flags_o     (clr_flags),
    .clr_illegal_o   (clr_illegal),
    .clr_done_o      (clr_done)
  );

  cx_req_fsm u_req (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .go_i             (go),
    .insn_i           (insn),
    .data0_i          (data0),
    .data1_i          (data1),
    .cx_req_valid_o   (cx_req_valid_o),
    .cx_req_ready_i   (cx_req_ready_i),
    .cx_resp_ready_o  (cx_resp_ready_o),
    .cx_resp_valid_i  (cx_resp_valid_i),
    .cx_resp_data_i   (cx_resp_data_i),
    .cx_resp_status_i (cx_resp_status_i),
    .cx_req_data0_o   (cx_req_data0_o),
    .cx_req_data1_o   (cx_req_data1_o),
    .cx_func_o        (cx_func_o),
    .cx_insn_o        (cx_insn_o),
    .busy_o           (busy),
    .result_o         (result),
    .illegal_o        (illegal_pulse),
    .done_o           (done_pulse),
    .status_o         (resp_status)
  );

  cx_status_csr #(
    .CNT_W (CNT_W)
  ) u_status (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .done_i        (done_pulse),
    .illegal_i     (illegal_pulse),
    .status_i      (resp_status),
    .clr_flags_i   (clr_flags),
    .clr_illegal_i (clr_illegal),
    .clr_done_i    (clr_done),
    .done_o        (done_flag),
    .illegal_o     (illegal_flag),
    .flags_o       (flags),
    .count_o       (count)
  );

endmodule

`default_nettype wire

//--- verification/cx_unit_model.sv
`timescale 1ns/10ps
`default_nettype none

module cx_unit_model import cx_pkg::*; #(
  parameter int unsigned SEED = 32'had18
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Request side
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [CX_DATA_W-1:0]   req_data0_i,
  input  logic [CX_DATA_W-1:0]   req_data1_i,
  input  logic [CX_FUNC_W-1:0]   func_i,

  // Response side
  input  logic                   resp_ready_i,
  output logic                   resp_valid_o,
  output logic [CX_DATA_W-1:0]   resp_data_o,
  output logic [CX_STATUS_W-1:0] resp_status_o
);

  int unsigned          seed_val;
  int unsigned          delay;
  int unsigned          waited;
  logic [CX_DATA_W-1:0] op_a;
  logic [CX_DATA_W-1:0] op_b;
  logic [CX_FUNC_W-1:0] op_func;

  // One transaction at a time, outputs change on the falling edge
  initial begin
    seed_val      = $urandom(SEED);
    req_ready_o   = 1'b0;
    resp_valid_o  = 1'b0;
    resp_data_o   = '0;
    resp_status_o = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && req_valid_i) begin
        delay = $urandom_range(4, 0);
        repeat (delay) @(negedge clk_i);
        op_a        = req_data0_i;
        op_b        = req_data1_i;
        op_func     = func_i;
        req_ready_o = 1'b1;
        @(negedge clk_i);
        req_ready_o = 1'b0;

        delay = $urandom_range(4, 0);
        repeat (delay) @(negedge clk_i);
        // Answer only once the tracker takes responses
        waited = 0;
        while (resp_ready_i !== 1'b1 && waited < 8) begin
          @(negedge clk_i);
          waited++;
        end
        // Func bit 0 picks add or xor, bits 4:1 are the status
        resp_data_o   = op_func[0] ? (op_a ^ op_b) : (op_a + op_b);
        resp_status_o = op_func[4:1];
        resp_valid_o  = 1'b1;
        @(negedge clk_i);
        resp_valid_o  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/cx_host_chk.sv
`timescale 1ns/10ps
`default_nettype none

module cx_host_chk import cx_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input logic                 resp_ready_i,
  input logic [CX_DATA_W-1:0] req_data0_i,
  input logic [CX_DATA_W-1:0] req_data1_i,
  input logic [CX_FUNC_W-1:0] func_i,
  input logic [CX_DATA_W-1:0] insn_i,
  input logic                 wb_cyc_i,
  input logic                 wb_stb_i,
  input logic                 wb_ack_i
);

  int unsigned fail_count = 0;

  // Request held with a frozen payload until the unit takes it
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_data0_i) &&
      $stable(req_data1_i) && $stable(func_i) && $stable(insn_i))
    else begin
      $error("CX request dropped or changed before ready");
      fail_count++;
    end

  req_resp_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_valid_i && resp_ready_i))
    else begin
      $error("CX request valid and response ready high together");
      fail_count++;
    end

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |-> wb_cyc_i && wb_stb_i)
    else begin
      $error("Wishbone ack outside an active cycle");
      fail_count++;
    end

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("Wishbone ack high for two cycles in a row");
      fail_count++;
    end

endmodule

bind cx_host_top cx_host_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_valid_i  (u_req.cx_req_valid_o),
  .req_ready_i  (u_req.cx_req_ready_i),
  .resp_ready_i (u_req.cx_resp_ready_o),
  .req_data0_i  (u_req.cx_req_data0_o),
  .req_data1_i  (u_req.cx_req_data1_o),
  .func_i       (u_req.cx_func_o),
  .insn_i       (u_req.cx_insn_o),
  .wb_cyc_i     (u_regs.wb_cyc_i),
  .wb_stb_i     (u_regs.wb_stb_i),
  .wb_ack_i     (u_regs.wb_ack_o)
);

`default_nettype wire

//--- verification/cx_host_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cx_host_tb import cx_pkg::*; ();

  localparam int NUM_ENTRIES  = 6;
  localparam int ACK_TIMEOUT  = 20;
  localparam int IDLE_TIMEOUT = 40;

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [2:0]             wb_adr;
  logic [CX_DATA_W-1:0]   wb_dat_w;
  logic [CX_DATA_W-1:0]   wb_dat_r;
  logic                   wb_ack;
  logic                   cx_req_valid_o;
  logic                   cx_req_ready_i;
  logic                   cx_resp_ready_o;
  logic                   cx_resp_valid_i;
  logic [CX_DATA_W-1:0]   cx_resp_data_i;
  logic [CX_STATUS_W-1:0] cx_resp_status_i;
  logic [CX_DATA_W-1:0]   cx_req_data0_o;
  logic [CX_DATA_W-1:0]   cx_req_data1_o;
  logic [CX_FUNC_W-1:0]   cx_func_o;
  logic [CX_DATA_W-1:0]   cx_insn_o;
  logic [CX_SEL_W-1:0]    cx_cxu_id_o;
  logic [CX_SEL_W-1:0]    cx_state_id_o;
  logic [CX_SEL_W-1:0]    cx_virt_state_id_o;

  // Stimulus table
  string                tbl_name  [NUM_ENTRIES];
  logic [CX_DATA_W-1:0] tbl_insn  [NUM_ENTRIES];
  logic [CX_DATA_W-1:0] tbl_data0 [NUM_ENTRIES];
  logic [CX_DATA_W-1:0] tbl_data1 [NUM_ENTRIES];
  logic [5:0]           tbl_sel   [NUM_ENTRIES];
  logic                 tbl_legal [NUM_ENTRIES];

  int err_count  = 0;
  int test_count = 0;
  int fail_tests = 0;

  cx_host_top #(.CNT_W(8)) dut (
    .clk_i (clk), .rst_ni (rst_n),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
    .cx_req_valid_o (cx_req_valid_o), .cx_req_ready_i (cx_req_ready_i),
    .cx_resp_ready_o (cx_resp_ready_o), .cx_resp_valid_i (cx_resp_valid_i),
    .cx_resp_data_i (cx_resp_data_i), .cx_resp_status_i (cx_resp_status_i),
    .cx_req_data0_o (cx_req_data0_o), .cx_req_data1_o (cx_req_data1_o),
    .cx_func_o (cx_func_o), .cx_insn_o (cx_insn_o), .cx_cxu_id_o (cx_cxu_id_o),
    .cx_state_id_o (cx_state_id_o), .cx_virt_state_id_o (cx_virt_state_id_o)
  );

  cx_unit_model #(.SEED(32'had18)) u_unit (
    .clk_i (clk), .rst_ni (rst_n),
    .req_valid_i (cx_req_valid_o), .req_ready_o (cx_req_ready_i),
    .req_data0_i (cx_req_data0_o), .req_data1_i (cx_req_data1_o), .func_i (cx_func_o),
    .resp_ready_i (cx_resp_ready_o), .resp_valid_o (cx_resp_valid_i),
    .resp_data_o (cx_resp_data_i), .resp_status_o (cx_resp_status_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      err_count++;
    end
  endtask

  // One classic cycle, held through the edge that commits a write
  task automatic bus_cycle(input logic we, input logic [2:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited   = 0;
    rdata    = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (wb_ack !== 1'b1 && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (wb_ack !== 1'b1) begin
      $display("Timeout: no Wishbone ack for offset %0d", adr);
      err_count++;
    end else begin
      rdata = wb_dat_r;
    end
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  task automatic wait_idle(input string name);
    logic [31:0] st;
    int          polls;
    polls = 0;
    wb_read(REG_STATUS, st);
    while (st[ST_BUSY] !== 1'b0 && polls < IDLE_TIMEOUT) begin
      wb_read(REG_STATUS, st);
      polls++;
    end
    if (st[ST_BUSY] !== 1'b0) begin
      $display("Timeout: %s still busy after %0d status reads", name, polls);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  function automatic logic [31:0] make_insn(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [6:0] opcode);
    cx_insn_u w;
    w.r.funct7 = funct7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = funct3;
    w.r.rd     = rd;
    w.r.opcode = opcode;
    return w;
  endfunction

  // Unit rule: func bit 0 selects xor over add
  function automatic logic [31:0] expected_result(input logic [31:0] insn,
                                                  input logic [31:0] a, input logic [31:0] b);
    cx_insn_u w;
    w = insn;
    if (w.f.func[0]) begin
      return a ^ b;
    end
    return a + b;
  endfunction

  task automatic add_entry(input int i, input string name, input logic [31:0] insn,
                           input logic [31:0] d0, input logic [31:0] d1,
                           input logic [5:0] sel, input logic legal);
    tbl_name[i]  = name;
    tbl_insn[i]  = insn;
    tbl_data0[i] = d0;
    tbl_data1[i] = d1;
    tbl_sel[i]   = sel;
    tbl_legal[i] = legal;
  endtask

  ////////////////////////////////////////////////////////////
  // Table entry runner
  ////////////////////////////////////////////////////////////

  task automatic run_entry(input int i);
    logic [31:0] rdata;
    logic [31:0] st_before;
    cx_insn_u    w;
    string       n;
    w = tbl_insn[i];
    n = tbl_name[i];
    wb_write(REG_INSN, tbl_insn[i]);
    wb_write(REG_DATA0, tbl_data0[i]);
    wb_write(REG_DATA1, tbl_data1[i]);
    wb_write(REG_SEL, {26'h0, tbl_sel[i]});
    // Illegal entries start from a cleared illegal flag
    if (!tbl_legal[i]) begin
      wb_write(REG_STATUS, 32'h1 << ST_ILLEGAL);
    end
    wb_read(REG_STATUS, st_before);
    wb_write(REG_CMD, 32'h1);
    if (tbl_legal[i]) begin
      // Request is up on the clock after the GO ack
      check_eq({n, " req_valid"}, 32'h1, cx_req_valid_o);
      check_eq({n, " func"}, w.f.func, cx_func_o);
      check_eq({n, " insn"}, tbl_insn[i], cx_insn_o);
      check_eq({n, " data0"}, tbl_data0[i], cx_req_data0_o);
      check_eq({n, " data1"}, tbl_data1[i], cx_req_data1_o);
      check_eq({n, " selectors"}, tbl_sel[i],
               {cx_virt_state_id_o, cx_state_id_o, cx_cxu_id_o});
      // Second GO lands while busy
      wb_write(REG_CMD, 32'h1);
      wait_idle(n);
      wb_read(REG_RESULT, rdata);
      check_eq({n, " result"}, expected_result(tbl_insn[i], tbl_data0[i], tbl_data1[i]), rdata);
      wb_read(REG_STATUS, rdata);
      check_eq({n, " done"}, 32'h1, rdata[ST_DONE]);
      check_eq({n, " count"}, st_before[ST_CNT_LSB +: 8] + 8'd1, rdata[ST_CNT_LSB +: 8]);
    end else begin
      for (int c = 0; c < 10; c++) begin
        @(negedge clk);
        check_eq({n, " req_valid low"}, 32'h0, cx_req_valid_o);
        check_eq({n, " resp_ready low"}, 32'h0, cx_resp_ready_o);
      end
      wb_read(REG_STATUS, rdata);
      check_eq({n, " busy"}, 32'h0, rdata[ST_BUSY]);
      check_eq({n, " illegal"}, 32'h1, rdata[ST_ILLEGAL]);
      check_eq({n, " count"}, st_before[ST_CNT_LSB +: 8], rdata[ST_CNT_LSB +: 8]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]          rdata;
    logic [CX_STATUS_W-1:0] exp_flags;
    int                   exp_count;
    int                   errs_before;
    cx_insn_u             w;

    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;

    add_entry(0, "custom0_add", make_insn(7'h01, 5'd3, 5'd2, 3'd0, 5'b00010, OPC_CUSTOM0),
              32'h0000_1234, 32'h0000_4321, 6'h05, 1'b1);
    add_entry(1, "custom1_xor", make_insn(7'h7f, 5'd31, 5'd30, 3'd7, 5'b00101, OPC_CUSTOM1),
              32'hFFFF_0000, 32'h0F0F_0F0F, 6'h2A, 1'b1);
    add_entry(2, "op_illegal", make_insn(7'h00, 5'd1, 5'd2, 3'd0, 5'b11110, 7'b0110011),
              32'h1111_1111, 32'h2222_2222, 6'h01, 1'b0);
    add_entry(3, "custom1_add_wrap", make_insn(7'h20, 5'd4, 5'd5, 3'd3, 5'b01000, OPC_CUSTOM1),
              32'hFFFF_FFF0, 32'h0000_0020, 6'h3F, 1'b1);
    add_entry(4, "custom0_xor", make_insn(7'h15, 5'd9, 5'd8, 3'd5, 5'b10001, OPC_CUSTOM0),
              32'hCAFE_F00D, 32'h1234_5678, 6'h12, 1'b1);
    add_entry(5, "load_illegal", make_insn(7'h00, 5'd0, 5'd1, 3'd2, 5'b11111, 7'b0000011),
              32'h3333_3333, 32'h4444_4444, 6'h00, 1'b0);

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    errs_before = err_count;
    check_eq("reset req_valid", 32'h0, cx_req_valid_o);
    check_eq("reset resp_ready", 32'h0, cx_resp_ready_o);
    check_eq("reset ack", 32'h0, wb_ack);
    wb_read(REG_STATUS, rdata);
    check_eq("reset status", 32'h0, rdata);
    wb_read(REG_RESULT, rdata);
    check_eq("reset result", 32'h0, rdata);
    report_test("reset_values", errs_before);

    errs_before = err_count;
    wb_write(REG_INSN, 32'hDEAD_BEEF);
    wb_write(REG_DATA0, 32'h1234_5678);
    wb_write(REG_DATA1, 32'hA5A5_5A5A);
    wb_write(REG_SEL, 32'hFFFF_FF39);
    wb_read(REG_INSN, rdata);
    check_eq("readback insn", 32'hDEAD_BEEF, rdata);
    wb_read(REG_DATA0, rdata);
    check_eq("readback data0", 32'h1234_5678, rdata);
    wb_read(REG_DATA1, rdata);
    check_eq("readback data1", 32'hA5A5_5A5A, rdata);
    wb_read(REG_SEL, rdata);
    check_eq("readback sel", 32'h0000_0039, rdata);
    wb_read(REG_CMD, rdata);
    check_eq("readback cmd", 32'h0, rdata);
    wb_read(3'd7, rdata);
    check_eq("readback unmapped", 32'h0, rdata);
    check_eq("sel cxu_id", 32'h1, cx_cxu_id_o);
    check_eq("sel state_id", 32'h2, cx_state_id_o);
    check_eq("sel virt_state_id", 32'h3, cx_virt_state_id_o);
    report_test("register_access", errs_before);

    exp_flags = '0;
    exp_count = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      errs_before = err_count;
      run_entry(i);
      report_test(tbl_name[i], errs_before);
      if (tbl_legal[i]) begin
        w         = tbl_insn[i];
        exp_flags = exp_flags | w.f.func[4:1];
        exp_count++;
      end
    end

    errs_before = err_count;
    wb_read(REG_STATUS, rdata);
    check_eq("final flags", exp_flags, rdata[ST_FLAGS_LSB +: CX_STATUS_W]);
    check_eq("final count", exp_count, rdata[ST_CNT_LSB +: 8]);
    check_eq("final done", 32'h1, rdata[ST_DONE]);
    check_eq("final illegal", 32'h1, rdata[ST_ILLEGAL]);
    check_eq("final busy", 32'h0, rdata[ST_BUSY]);
    report_test("final_status", errs_before);

    // Write-1-to-clear, one field at a time
    errs_before = err_count;
    wb_write(REG_STATUS, 32'h0000_00F0);
    wb_read(REG_STATUS, rdata);
    check_eq("clear flags", 32'h0, rdata[ST_FLAGS_LSB +: CX_STATUS_W]);
    check_eq("clear flags keeps count", exp_count, rdata[ST_CNT_LSB +: 8]);
    wb_write(REG_STATUS, 32'h1 << ST_ILLEGAL);
    wb_read(REG_STATUS, rdata);
    check_eq("clear illegal", 32'h0, rdata[ST_ILLEGAL]);
    wb_write(REG_STATUS, 32'h1 << ST_DONE);
    wb_read(REG_STATUS, rdata);
    check_eq("clear done", 32'h0, rdata[ST_DONE]);
    check_eq("clear count", 32'h0, rdata[ST_CNT_LSB +: 8]);
    check_eq("cleared status", 32'h0, rdata);
    report_test("clear_status", errs_before);

    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_count, fail_tests, err_count, dut.u_chk.fail_count);
    if (err_count == 0 && dut.u_chk.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
source/cx_pkg.sv
source/cx_wb_regs.sv
source/cx_req_fsm.sv
source/cx_status_csr.sv
source/cx_host_top.sv
verification/cx_unit_model.sv
verification/cx_host_chk.sv
verification/cx_host_tb.sv
